// ==== lockstep_pkg.sv ====
/* Shared definitions for the lockstep TCDM checker: the copy depth type,
 * the bus widths and the per-byte parity function used as ECC. */
package lockstep_pkg;

  // how much of each stream is duplicated and compared.
  typedef enum logic [1:0] {
    copy_full,      // everything is copied.
    copy_no_ecc,    // ecc stays on the main stream.
    copy_no_data,   // data stays on the main stream.
    copy_ctrl_only  // only control fields are copied.
  } copy_type_t;

  localparam int unsigned ADDR_W = 12;          // byte address.
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;  // one enable and one parity bit per byte.
  localparam int unsigned ID_W   = 4;

  // even parity over each byte of a word.
  function automatic logic [BE_W-1:0] parity_bytes(input logic [DATA_W-1:0] data);
    logic [BE_W-1:0] par;
    for (int b = 0; b < BE_W; b++) begin
      par[b] = ^data[8*b +: 8];
    end
    return par;
  endfunction

endpackage

// ==== tcdm_copy_source.sv ====
/* tcdm_copy_source: splits one initiator request into main and copy streams,
 * adds byte parity and compares the copy response with the main response. */
`timescale 1ns/1ps

module tcdm_copy_source #(
  parameter lockstep_pkg::copy_type_t COPY_TYPE = lockstep_pkg::copy_full
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_i,
  input  logic                            wen_i,
  input  logic [lockstep_pkg::ADDR_W-1:0] add_i,
  input  logic [lockstep_pkg::BE_W-1:0]   be_i,
  input  logic [lockstep_pkg::DATA_W-1:0] data_i,
  input  logic [lockstep_pkg::ID_W-1:0]   id_i,
  output logic                            gnt_o,
  output logic                            r_valid_o,
  output logic [lockstep_pkg::DATA_W-1:0] r_data_o,
  output logic [lockstep_pkg::ID_W-1:0]   r_id_o,
  output logic                            fault_o,
  output logic                            main_req, main_wen, copy_req, copy_wen,
  output logic [lockstep_pkg::ADDR_W-1:0] main_add, copy_add,
  output logic [lockstep_pkg::BE_W-1:0]   main_be, main_ecc, copy_be, copy_ecc,
  output logic [lockstep_pkg::DATA_W-1:0] main_data, copy_data,
  output logic [lockstep_pkg::ID_W-1:0]   main_id, copy_id,
  input  logic                            main_gnt, main_r_valid, copy_gnt, copy_r_valid,
  input  logic [lockstep_pkg::DATA_W-1:0] main_r_data, copy_r_data,
  input  logic [lockstep_pkg::BE_W-1:0]   main_r_ecc, copy_r_ecc,
  input  logic [lockstep_pkg::ID_W-1:0]   main_r_id, copy_r_id
);

  localparam bit has_data = (COPY_TYPE == lockstep_pkg::copy_full) ||
                            (COPY_TYPE == lockstep_pkg::copy_no_ecc);
  localparam bit has_ecc  = (COPY_TYPE == lockstep_pkg::copy_full) ||
                            (COPY_TYPE == lockstep_pkg::copy_no_data);

  logic [lockstep_pkg::BE_W-1:0] wr_ecc;
  logic                          ctrl_fault, data_fault, ecc_fault;
  logic [2:0]                    outstanding;  // requests without a response yet.

  assign wr_ecc = lockstep_pkg::parity_bytes(data_i);

  // main stream gets the whole request.
  assign main_req  = req_i;
  assign main_wen  = wen_i;
  assign main_add  = add_i;
  assign main_be   = be_i;
  assign main_data = data_i;
  assign main_ecc  = wr_ecc;
  assign main_id   = id_i;

  // copy stream; removed fields are tied low.
  assign copy_req  = req_i;
  assign copy_wen  = wen_i;
  assign copy_add  = add_i;
  assign copy_be   = be_i;
  assign copy_id   = id_i;
  assign copy_data = has_data ? data_i : '0;
  assign copy_ecc  = has_ecc ? wr_ecc : '0;

  // the initiator only ever sees the main response.
  assign gnt_o     = main_gnt;
  assign r_valid_o = main_r_valid;
  assign r_data_o  = main_r_data;
  assign r_id_o    = main_r_id;

  assign ctrl_fault = (main_gnt != copy_gnt) | (main_r_valid != copy_r_valid) |
                      (main_r_valid & (main_r_id != copy_r_id));
  assign data_fault = has_data & main_r_valid & (main_r_data != copy_r_data);
  assign ecc_fault  = has_ecc & main_r_valid & (main_r_ecc != copy_r_ecc);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_o     <= 1'b0;
      outstanding <= '0;
    end else begin
      fault_o     <= ctrl_fault | data_fault | ecc_fault;  // registered to cut the path.
      outstanding <= outstanding + 3'(req_i & main_gnt) - 3'(main_r_valid);
    end
  end

  // a response has to belong to a request granted in an earlier cycle.
  assert property (@(posedge clk_i) disable iff (!rst_ni) main_r_valid |-> outstanding != '0);

endmodule

// ==== tcdm_pipe_stage.sv ====
/* tcdm_pipe_stage: one register slice per stream and direction, with
 * fault injection masks on the copy request and the copy response. */
`timescale 1ns/1ps

module tcdm_pipe_stage #(
  parameter lockstep_pkg::copy_type_t COPY_TYPE = lockstep_pkg::copy_full
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [lockstep_pkg::DATA_W-1:0] req_flip_i,
  input  logic [lockstep_pkg::DATA_W-1:0] rsp_flip_i,
  // upstream side, towards the source.
  input  logic                            up_main_req, up_main_wen, up_copy_req, up_copy_wen,
  input  logic [lockstep_pkg::ADDR_W-1:0] up_main_add, up_copy_add,
  input  logic [lockstep_pkg::BE_W-1:0]   up_main_be, up_main_ecc, up_copy_be, up_copy_ecc,
  input  logic [lockstep_pkg::DATA_W-1:0] up_main_data, up_copy_data,
  input  logic [lockstep_pkg::ID_W-1:0]   up_main_id, up_copy_id,
  output logic                            up_main_gnt, up_main_r_valid,
  output logic                            up_copy_gnt, up_copy_r_valid,
  output logic [lockstep_pkg::DATA_W-1:0] up_main_r_data, up_copy_r_data,
  output logic [lockstep_pkg::BE_W-1:0]   up_main_r_ecc, up_copy_r_ecc,
  output logic [lockstep_pkg::ID_W-1:0]   up_main_r_id, up_copy_r_id,
  // downstream side, towards the sink.
  output logic                            dn_main_req, dn_main_wen, dn_copy_req, dn_copy_wen,
  output logic [lockstep_pkg::ADDR_W-1:0] dn_main_add, dn_copy_add,
  output logic [lockstep_pkg::BE_W-1:0]   dn_main_be, dn_main_ecc, dn_copy_be, dn_copy_ecc,
  output logic [lockstep_pkg::DATA_W-1:0] dn_main_data, dn_copy_data,
  output logic [lockstep_pkg::ID_W-1:0]   dn_main_id, dn_copy_id,
  input  logic                            dn_main_gnt, dn_main_r_valid,
  input  logic                            dn_copy_gnt, dn_copy_r_valid,
  input  logic [lockstep_pkg::DATA_W-1:0] dn_main_r_data, dn_copy_r_data,
  input  logic [lockstep_pkg::BE_W-1:0]   dn_main_r_ecc, dn_copy_r_ecc,
  input  logic [lockstep_pkg::ID_W-1:0]   dn_main_r_id, dn_copy_r_id
);

  localparam bit has_data = (COPY_TYPE == lockstep_pkg::copy_full) ||
                            (COPY_TYPE == lockstep_pkg::copy_no_ecc);
  localparam bit has_ecc  = (COPY_TYPE == lockstep_pkg::copy_full) ||
                            (COPY_TYPE == lockstep_pkg::copy_no_data);

  assign up_main_gnt = dn_main_gnt;  // grant is not registered.
  assign up_copy_gnt = dn_copy_gnt;

  // **************************************************
  // valid bits, cleared by reset
  // **************************************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dn_main_req     <= 1'b0;
      dn_copy_req     <= 1'b0;
      up_main_r_valid <= 1'b0;
      up_copy_r_valid <= 1'b0;
    end else begin
      dn_main_req     <= up_main_req;
      dn_copy_req     <= up_copy_req;
      up_main_r_valid <= dn_main_r_valid;
      up_copy_r_valid <= dn_copy_r_valid;
    end
  end

  // **************************************************
  // payload slices
  // **************************************************
  always_ff @(posedge clk_i) begin
    dn_main_wen    <= up_main_wen;
    dn_main_add    <= up_main_add;
    dn_main_be     <= up_main_be;
    dn_main_data   <= up_main_data;
    dn_main_ecc    <= up_main_ecc;
    dn_main_id     <= up_main_id;
    up_main_r_data <= dn_main_r_data;
    up_main_r_ecc  <= dn_main_r_ecc;
    up_main_r_id   <= dn_main_r_id;
    dn_copy_wen    <= up_copy_wen;
    dn_copy_be     <= up_copy_be;
    dn_copy_id     <= up_copy_id;
    // without a data copy the masks land on address and id instead.
    dn_copy_add    <= has_data ? up_copy_add
                               : up_copy_add ^ req_flip_i[lockstep_pkg::ADDR_W-1:0];
    up_copy_r_id   <= has_data ? dn_copy_r_id
                               : dn_copy_r_id ^ rsp_flip_i[lockstep_pkg::ID_W-1:0];
  end

  if (has_data) begin : g_copy_data
    always_ff @(posedge clk_i) begin
      dn_copy_data   <= up_copy_data ^ req_flip_i;
      up_copy_r_data <= dn_copy_r_data ^ rsp_flip_i;
    end
  end else begin : g_no_copy_data
    assign dn_copy_data   = '0;
    assign up_copy_r_data = '0;
  end

  if (has_ecc) begin : g_copy_ecc
    always_ff @(posedge clk_i) begin
      dn_copy_ecc   <= up_copy_ecc;
      up_copy_r_ecc <= dn_copy_r_ecc;
    end
  end else begin : g_no_copy_ecc
    assign dn_copy_ecc   = '0;
    assign up_copy_r_ecc = '0;
  end

endmodule

// ==== tcdm_copy_sink.sv ====
/* tcdm_copy_sink: forwards the main request to the memory, checks the copy
 * request against it and mirrors the memory response onto both streams. */
`timescale 1ns/1ps

module tcdm_copy_sink #(
  parameter lockstep_pkg::copy_type_t COPY_TYPE = lockstep_pkg::copy_full
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            main_req, main_wen, copy_req, copy_wen,
  input  logic [lockstep_pkg::ADDR_W-1:0] main_add, copy_add,
  input  logic [lockstep_pkg::BE_W-1:0]   main_be, main_ecc, copy_be, copy_ecc,
  input  logic [lockstep_pkg::DATA_W-1:0] main_data, copy_data,
  input  logic [lockstep_pkg::ID_W-1:0]   main_id, copy_id,
  output logic                            main_gnt, main_r_valid, copy_gnt, copy_r_valid,
  output logic [lockstep_pkg::DATA_W-1:0] main_r_data, copy_r_data,
  output logic [lockstep_pkg::BE_W-1:0]   main_r_ecc, copy_r_ecc,
  output logic [lockstep_pkg::ID_W-1:0]   main_r_id, copy_r_id,
  // memory side.
  output logic                            mem_req, mem_wen,
  output logic [lockstep_pkg::ADDR_W-1:0] mem_add,
  output logic [lockstep_pkg::BE_W-1:0]   mem_be, mem_ecc,
  output logic [lockstep_pkg::DATA_W-1:0] mem_data,
  output logic [lockstep_pkg::ID_W-1:0]   mem_id,
  input  logic                            mem_gnt, mem_r_valid,
  input  logic [lockstep_pkg::DATA_W-1:0] mem_r_data,
  input  logic [lockstep_pkg::BE_W-1:0]   mem_r_ecc,
  input  logic [lockstep_pkg::ID_W-1:0]   mem_r_id,
  output logic                            fault_o
);

  localparam bit has_data = (COPY_TYPE == lockstep_pkg::copy_full) ||
                            (COPY_TYPE == lockstep_pkg::copy_no_ecc);
  localparam bit has_ecc  = (COPY_TYPE == lockstep_pkg::copy_full) ||
                            (COPY_TYPE == lockstep_pkg::copy_no_data);

  logic ctrl_fault, data_fault, ecc_fault;

  // only the main request reaches the memory.
  assign mem_req  = main_req;
  assign mem_wen  = main_wen;
  assign mem_add  = main_add;
  assign mem_be   = main_be;
  assign mem_data = main_data;
  assign mem_ecc  = main_ecc;
  assign mem_id   = main_id;

  assign main_gnt     = mem_gnt;
  assign main_r_valid = mem_r_valid;
  assign main_r_data  = mem_r_data;
  assign main_r_ecc   = mem_r_ecc;
  assign main_r_id    = mem_r_id;

  // the copy response is a mirror of the main one.
  assign copy_gnt     = mem_gnt;
  assign copy_r_valid = mem_r_valid;
  assign copy_r_id    = mem_r_id;
  assign copy_r_data  = has_data ? mem_r_data : '0;
  assign copy_r_ecc   = has_ecc ? mem_r_ecc : '0;

  assign ctrl_fault = (main_req != copy_req) | (main_wen != copy_wen) |
                      (main_add != copy_add) | (main_be != copy_be) |
                      (main_id != copy_id);
  assign data_fault = has_data & (main_data != copy_data);
  assign ecc_fault  = has_ecc & (main_ecc != copy_ecc);  // catches ecc damage in the stage.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_o <= 1'b0;
    end else begin
      fault_o <= ctrl_fault | data_fault | ecc_fault;
    end
  end

  // the copy stream borrows the memory grant, so a copy request must see it high.
  assert property (@(posedge clk_i) disable iff (!rst_ni) copy_req |-> copy_gnt);

endmodule

// ==== tcdm_sram_target.sv ====
/* tcdm_sram_target: 64-word byte-enabled memory that always grants,
 * drops bytes with bad parity and answers one cycle after each request. */
`timescale 1ns/1ps

module tcdm_sram_target (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req,
  input  logic [lockstep_pkg::ADDR_W-1:0] add,
  input  logic                            wen,  // 1 is a read.
  input  logic [lockstep_pkg::BE_W-1:0]   be,
  input  logic [lockstep_pkg::DATA_W-1:0] data,
  input  logic [lockstep_pkg::BE_W-1:0]   ecc,
  input  logic [lockstep_pkg::ID_W-1:0]   id,
  output logic                            gnt,
  output logic                            r_valid,
  output logic [lockstep_pkg::DATA_W-1:0] r_data,
  output logic [lockstep_pkg::BE_W-1:0]   r_ecc,
  output logic [lockstep_pkg::ID_W-1:0]   r_id
);

  localparam int unsigned depth = 64;

  logic [lockstep_pkg::DATA_W-1:0] mem_q [depth];
  logic [$clog2(depth)-1:0]        idx;     // word address.
  logic [lockstep_pkg::BE_W-1:0]   par_ok;  // byte parity matches its data.

  assign idx    = add[2 +: $clog2(depth)];
  assign par_ok = ~(ecc ^ lockstep_pkg::parity_bytes(data));
  assign gnt    = 1'b1;  // never stalls.

  always_ff @(posedge clk_i) begin
    if (req && !wen) begin
      for (int b = 0; b < lockstep_pkg::BE_W; b++) begin
        if (be[b] && par_ok[b]) begin
          mem_q[idx][8*b +: 8] <= data[8*b +: 8];
        end
      end
    end
    if (req) begin
      r_data <= mem_q[idx];  // old word, also on writes.
      r_ecc  <= lockstep_pkg::parity_bytes(mem_q[idx]);
      r_id   <= id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= req & gnt;
    end
  end

endmodule

// ==== lockstep_tcdm_top.sv ====
/* lockstep_tcdm_top: copy source, pipe stage, copy sink and SRAM target
 * in a chain, with request and response fault outputs. */
`timescale 1ns/1ps

module lockstep_tcdm_top #(
  parameter lockstep_pkg::copy_type_t COPY_TYPE = lockstep_pkg::copy_full
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_i,
  input  logic [lockstep_pkg::ADDR_W-1:0] add_i,
  input  logic                            wen_i,
  input  logic [lockstep_pkg::BE_W-1:0]   be_i,
  input  logic [lockstep_pkg::DATA_W-1:0] data_i,
  input  logic [lockstep_pkg::ID_W-1:0]   id_i,
  input  logic [lockstep_pkg::DATA_W-1:0] req_flip_i,
  input  logic [lockstep_pkg::DATA_W-1:0] rsp_flip_i,
  output logic                            gnt_o,
  output logic                            r_valid_o,
  output logic [lockstep_pkg::DATA_W-1:0] r_data_o,
  output logic [lockstep_pkg::ID_W-1:0]   r_id_o,
  output logic                            req_fault_o,
  output logic                            rsp_fault_o
);

  // **************************************************
  // source to stage
  // **************************************************
  logic                            up_main_req, up_main_wen, up_main_gnt, up_main_r_valid;
  logic                            up_copy_req, up_copy_wen, up_copy_gnt, up_copy_r_valid;
  logic [lockstep_pkg::ADDR_W-1:0] up_main_add, up_copy_add;
  logic [lockstep_pkg::BE_W-1:0]   up_main_be, up_main_ecc, up_main_r_ecc;
  logic [lockstep_pkg::BE_W-1:0]   up_copy_be, up_copy_ecc, up_copy_r_ecc;
  logic [lockstep_pkg::DATA_W-1:0] up_main_data, up_main_r_data, up_copy_data, up_copy_r_data;
  logic [lockstep_pkg::ID_W-1:0]   up_main_id, up_main_r_id, up_copy_id, up_copy_r_id;

  // **************************************************
  // stage to sink, and sink to memory
  // **************************************************
  logic                            dn_main_req, dn_main_wen, dn_main_gnt, dn_main_r_valid;
  logic                            dn_copy_req, dn_copy_wen, dn_copy_gnt, dn_copy_r_valid;
  logic [lockstep_pkg::ADDR_W-1:0] dn_main_add, dn_copy_add;
  logic [lockstep_pkg::BE_W-1:0]   dn_main_be, dn_main_ecc, dn_main_r_ecc;
  logic [lockstep_pkg::BE_W-1:0]   dn_copy_be, dn_copy_ecc, dn_copy_r_ecc;
  logic [lockstep_pkg::DATA_W-1:0] dn_main_data, dn_main_r_data, dn_copy_data, dn_copy_r_data;
  logic [lockstep_pkg::ID_W-1:0]   dn_main_id, dn_main_r_id, dn_copy_id, dn_copy_r_id;
  logic                            mem_req, mem_wen, mem_gnt, mem_r_valid;
  logic [lockstep_pkg::ADDR_W-1:0] mem_add;
  logic [lockstep_pkg::BE_W-1:0]   mem_be, mem_ecc, mem_r_ecc;
  logic [lockstep_pkg::DATA_W-1:0] mem_data, mem_r_data;
  logic [lockstep_pkg::ID_W-1:0]   mem_id, mem_r_id;

  tcdm_copy_source #(.COPY_TYPE(COPY_TYPE)) i_copy_source (
    .clk_i, .rst_ni, .req_i, .wen_i, .add_i, .be_i, .data_i, .id_i,
    .gnt_o, .r_valid_o, .r_data_o, .r_id_o, .fault_o(rsp_fault_o),
    .main_req(up_main_req), .main_wen(up_main_wen), .main_add(up_main_add),
    .main_be(up_main_be), .main_ecc(up_main_ecc), .main_data(up_main_data),
    .main_id(up_main_id), .main_gnt(up_main_gnt), .main_r_valid(up_main_r_valid),
    .main_r_data(up_main_r_data), .main_r_ecc(up_main_r_ecc), .main_r_id(up_main_r_id),
    .copy_req(up_copy_req), .copy_wen(up_copy_wen), .copy_add(up_copy_add),
    .copy_be(up_copy_be), .copy_ecc(up_copy_ecc), .copy_data(up_copy_data),
    .copy_id(up_copy_id), .copy_gnt(up_copy_gnt), .copy_r_valid(up_copy_r_valid),
    .copy_r_data(up_copy_r_data), .copy_r_ecc(up_copy_r_ecc), .copy_r_id(up_copy_r_id)
  );

  tcdm_pipe_stage #(.COPY_TYPE(COPY_TYPE)) i_pipe_stage (
    .clk_i, .rst_ni, .req_flip_i, .rsp_flip_i,
    .up_main_req, .up_main_wen, .up_main_add, .up_main_be, .up_main_ecc, .up_main_data,
    .up_main_id, .up_main_gnt, .up_main_r_valid, .up_main_r_data, .up_main_r_ecc,
    .up_main_r_id,
    .up_copy_req, .up_copy_wen, .up_copy_add, .up_copy_be, .up_copy_ecc, .up_copy_data,
    .up_copy_id, .up_copy_gnt, .up_copy_r_valid, .up_copy_r_data, .up_copy_r_ecc,
    .up_copy_r_id,
    .dn_main_req, .dn_main_wen, .dn_main_add, .dn_main_be, .dn_main_ecc, .dn_main_data,
    .dn_main_id, .dn_main_gnt, .dn_main_r_valid, .dn_main_r_data, .dn_main_r_ecc,
    .dn_main_r_id,
    .dn_copy_req, .dn_copy_wen, .dn_copy_add, .dn_copy_be, .dn_copy_ecc, .dn_copy_data,
    .dn_copy_id, .dn_copy_gnt, .dn_copy_r_valid, .dn_copy_r_data, .dn_copy_r_ecc,
    .dn_copy_r_id
  );

  tcdm_copy_sink #(.COPY_TYPE(COPY_TYPE)) i_copy_sink (
    .clk_i, .rst_ni, .fault_o(req_fault_o),
    .main_req(dn_main_req), .main_wen(dn_main_wen), .main_add(dn_main_add),
    .main_be(dn_main_be), .main_ecc(dn_main_ecc), .main_data(dn_main_data),
    .main_id(dn_main_id), .main_gnt(dn_main_gnt), .main_r_valid(dn_main_r_valid),
    .main_r_data(dn_main_r_data), .main_r_ecc(dn_main_r_ecc), .main_r_id(dn_main_r_id),
    .copy_req(dn_copy_req), .copy_wen(dn_copy_wen), .copy_add(dn_copy_add),
    .copy_be(dn_copy_be), .copy_ecc(dn_copy_ecc), .copy_data(dn_copy_data),
    .copy_id(dn_copy_id), .copy_gnt(dn_copy_gnt), .copy_r_valid(dn_copy_r_valid),
    .copy_r_data(dn_copy_r_data), .copy_r_ecc(dn_copy_r_ecc), .copy_r_id(dn_copy_r_id),
    .mem_req, .mem_wen, .mem_add, .mem_be, .mem_ecc, .mem_data, .mem_id,
    .mem_gnt, .mem_r_valid, .mem_r_data, .mem_r_ecc, .mem_r_id
  );

  tcdm_sram_target i_sram_target (
    .clk_i, .rst_ni, .req(mem_req), .add(mem_add), .wen(mem_wen), .be(mem_be),
    .data(mem_data), .ecc(mem_ecc), .id(mem_id), .gnt(mem_gnt), .r_valid(mem_r_valid),
    .r_data(mem_r_data), .r_ecc(mem_r_ecc), .r_id(mem_r_id)
  );

endmodule

// ==== tb_lockstep_tcdm.sv ====
/* Testbench for the lockstep TCDM checker: stimulus table applied in a loop,
 * reference memory, response and fault checks at fixed delays, watchdog. */
`timescale 1ns/1ps

module tb_lockstep_tcdm;

  localparam logic rd = 1'b1;  // wen encoding, 1 is a read.
  localparam logic wr = 1'b0;

  logic                            clk_i = 1'b0;
  logic                            rst_ni;
  logic                            req_i, wen_i, gnt_o, r_valid_o;
  logic [lockstep_pkg::ADDR_W-1:0] add_i;
  logic [lockstep_pkg::BE_W-1:0]   be_i;
  logic [lockstep_pkg::DATA_W-1:0] data_i, req_flip_i, rsp_flip_i, r_data_o;
  logic [lockstep_pkg::ID_W-1:0]   id_i, r_id_o;
  logic                            req_fault_o, rsp_fault_o;

  // **************************************************
  // stimulus table and expected values
  // **************************************************
  logic                            wen_q [$];
  logic [lockstep_pkg::ADDR_W-1:0] addr_q [$];
  logic [lockstep_pkg::BE_W-1:0]   be_q [$];
  logic [lockstep_pkg::DATA_W-1:0] rqf_q [$], rsf_q [$];  // flip masks.
  logic                            erq_q [$], ers_q [$];  // expected faults.
  logic [lockstep_pkg::DATA_W-1:0] exp_data_q [$];        // filled as requests go out.
  logic [lockstep_pkg::ID_W-1:0]   id_q [$];
  logic [lockstep_pkg::DATA_W-1:0] ref_mem [64];          // model of the sram words.
  int                              entry_err [$];
  int                              n_tests, n_checks, n_errors, n_passed;
  bit                              table_ready = 1'b0;

  lockstep_tcdm_top #(.COPY_TYPE(lockstep_pkg::copy_full)) i_lockstep_tcdm_top (
    .clk_i, .rst_ni, .req_i, .add_i, .wen_i, .be_i, .data_i, .id_i,
    .req_flip_i, .rsp_flip_i, .gnt_o, .r_valid_o, .r_data_o, .r_id_o,
    .req_fault_o, .rsp_fault_o
  );

  always #20 clk_i = ~clk_i;  // 40 ns period.

  task automatic add_entry(input logic w, input logic [lockstep_pkg::ADDR_W-1:0] a,
                           input logic [lockstep_pkg::BE_W-1:0] b,
                           input logic [lockstep_pkg::DATA_W-1:0] rqf,
                           input logic [lockstep_pkg::DATA_W-1:0] rsf,
                           input logic erq, input logic ers);
    wen_q.push_back(w);
    addr_q.push_back(a);
    be_q.push_back(b);
    rqf_q.push_back(rqf);
    rsf_q.push_back(rsf);
    erq_q.push_back(erq);
    ers_q.push_back(ers);
    entry_err.push_back(0);
  endtask

  task automatic build_table();
    // full words first, so every later read hits known bytes.
    add_entry(wr, 12'h000, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(wr, 12'h004, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(wr, 12'h008, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(wr, 12'h00c, 4'hf, 32'h0001_0000, 32'h0, 1'b1, 1'b0);  // copy data hit.
    add_entry(wr, 12'h010, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(rd, 12'h000, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(rd, 12'h00c, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);          // main write intact.
    add_entry(wr, 12'h004, 4'h3, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(rd, 12'h004, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);          // right after write.
    add_entry(wr, 12'h008, 4'h8, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(wr, 12'h010, 4'h5, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(rd, 12'h008, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(rd, 12'h010, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(rd, 12'h004, 4'hf, 32'h0000_0100, 32'h0, 1'b1, 1'b0);
    add_entry(rd, 12'h004, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);          // clean again.
    add_entry(rd, 12'h008, 4'hf, 32'h0, 32'h8000_0001, 1'b0, 1'b1);
    add_entry(rd, 12'h008, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(wr, 12'h014, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(rd, 12'hf14, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);          // upper bits alias.
    add_entry(wr, 12'h014, 4'h6, 32'h0, 32'h0000_00ff, 1'b0, 1'b1);  // write response too.
    add_entry(rd, 12'h014, 4'hf, 32'hffff_ffff, 32'h0000_0001, 1'b1, 1'b1);
    add_entry(rd, 12'h000, 4'hf, 32'h0, 32'h0, 1'b0, 1'b0);
  endtask

  task automatic note_mismatch(input int k, input string msg);
    n_errors++;
    if (k >= 0) begin
      entry_err[k]++;
      $display("Fail %0t: test %0d %s", $time, k, msg);
    end else begin
      $display("Fail %0t: outside any test, %s", $time, msg);
    end
  endtask

  // **************************************************
  // driving
  // **************************************************
  task automatic apply_request(input int k);
    logic [31:0] rnd;
    logic [5:0]  idx;
    rnd = $urandom;
    idx = addr_q[k][7:2];  // word index, as the sram decodes it.
    req_i      = 1'b1;
    wen_i      = wen_q[k];
    add_i      = addr_q[k];
    be_i       = be_q[k];
    data_i     = $urandom;
    id_i       = rnd[lockstep_pkg::ID_W-1:0];
    req_flip_i = rqf_q[k];
    id_q.push_back(id_i);
    exp_data_q.push_back(ref_mem[idx]);  // word before this request.
    if (!wen_q[k]) begin
      for (int b = 0; b < 4; b++) begin
        if (be_q[k][b]) ref_mem[idx][8*b +: 8] = data_i[8*b +: 8];
      end
    end
  endtask

  task automatic drive_idle();
    req_i      = 1'b0;
    wen_i      = 1'b1;
    be_i       = '0;
    req_flip_i = '0;
  endtask

  // **************************************************
  // checking, once per falling edge
  // **************************************************
  task automatic check_slot(input int s);
    int   kr, kq, kp;
    logic exp_rq, exp_rs;
    kr = s - 3;  // response of this request is due now.
    kq = s - 2;  // request fault of this one.
    kp = s - 4;  // response fault of this one.
    n_checks++;
    if (kr >= 0 && kr < n_tests) begin
      if (r_valid_o !== 1'b1) begin
        note_mismatch(kr, "r_valid_o low 3 cycles after the request");
      end else begin
        n_checks++;
        if (r_id_o !== id_q[kr]) begin
          note_mismatch(kr, $sformatf("r_id_o got %h expected %h", r_id_o, id_q[kr]));
        end
        if (wen_q[kr]) begin
          n_checks++;
          if (r_data_o !== exp_data_q[kr]) begin
            note_mismatch(kr, $sformatf("r_data_o got %h expected %h",
                                        r_data_o, exp_data_q[kr]));
          end
        end
      end
    end else if (r_valid_o !== 1'b0) begin
      note_mismatch(-1, "r_valid_o high with no request 3 cycles earlier");
    end
    exp_rq = 1'b0;
    exp_rs = 1'b0;
    if (kq >= 0 && kq < n_tests) exp_rq = erq_q[kq];
    if (kp >= 0 && kp < n_tests) exp_rs = ers_q[kp];
    n_checks += 2;
    if (req_fault_o !== exp_rq) begin
      note_mismatch((kq >= 0 && kq < n_tests) ? kq : -1,
                    $sformatf("req_fault_o got %b expected %b", req_fault_o, exp_rq));
    end
    if (rsp_fault_o !== exp_rs) begin
      note_mismatch((kp >= 0 && kp < n_tests) ? kp : -1,
                    $sformatf("rsp_fault_o got %b expected %b", rsp_fault_o, exp_rs));
    end
  endtask

  task automatic report_test(input int k);
    if (entry_err[k] == 0) begin
      n_passed++;
      $display("test %2d %s 0x%03h be %b: ok", k, wen_q[k] ? "read " : "write",
               addr_q[k], be_q[k]);
    end else begin
      $display("test %2d %s 0x%03h be %b: %0d errors", k, wen_q[k] ? "read " : "write",
               addr_q[k], be_q[k], entry_err[k]);
    end
  endtask

  initial begin
    void'($urandom(32'h165f));  // one seed for the whole run.
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    wen_i      = 1'b1;
    add_i      = '0;
    be_i       = '0;
    data_i     = '0;
    id_i       = '0;
    req_flip_i = '0;
    rsp_flip_i = '0;
    build_table();
    n_tests     = wen_q.size();
    table_ready = 1'b1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    n_checks++;
    if ((r_valid_o | req_fault_o | rsp_fault_o) !== 1'b0) begin
      note_mismatch(-1, "r_valid_o or a fault output high after reset");
    end
    for (int s = 0; s < n_tests + 4; s++) begin
      @(negedge clk_i);
      check_slot(s);
      if (s < n_tests) begin
        n_checks++;
        if (gnt_o !== 1'b1) note_mismatch(s, "gnt_o low while req_i high");
        apply_request(s);
      end else begin
        drive_idle();
      end
      // the response mask meets the response of the request 2 slots back.
      if (s >= 2 && s - 2 < n_tests) rsp_flip_i = rsf_q[s-2];
      else rsp_flip_i = '0;
      if (s >= 4) report_test(s - 4);
    end
    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_passed, n_tests - n_passed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog, table length plus 20 cycles from the start.
  initial begin
    int limit;
    wait (table_ready);
    limit = n_tests + 20;
    repeat (limit) @(posedge clk_i);
    $display("watchdog: the run did not finish within %0d cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== compile.f ====
lockstep_pkg.sv
tcdm_copy_source.sv
tcdm_pipe_stage.sv
tcdm_copy_sink.sv
tcdm_sram_target.sv
lockstep_tcdm_top.sv
tb_lockstep_tcdm.sv

// ==== run.sh ====
#!/bin/sh
# Builds the lockstep TCDM testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_lockstep_tcdm -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qxF "=== PASS ==="; then
  exit 0
fi
exit 1
